// File: common/axi_sram_pkg.sv
// Shared types, constants and burst address helpers for the AXI4 SRAM slave
package axi_sram_pkg;

    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 64;
    localparam int DATA_BYTES = DATA_BITS / 8;
    localparam int ID_BITS = 4;
    localparam int USER_BITS = 1;
    localparam int MEM_WORDS = 512;
    localparam int MEM_AW = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One AR or AW channel payload
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [7:0]           len;
        logic [2:0]           size;
        burst_e               burst;
        logic [ID_BITS-1:0]   id;
        logic [USER_BITS-1:0] user;
    } axi_ax_t;

    typedef struct packed {
        logic                  ar_valid;
        axi_ax_t               ar;
        logic                  aw_valid;
        axi_ax_t               aw;
        logic                  w_valid;
        logic [DATA_BITS-1:0]  w_data;
        logic [DATA_BYTES-1:0] w_strb;
        logic                  w_last;
        logic                  r_ready;
        logic                  b_ready;
    } axi_slv_in_t;

    typedef struct packed {
        logic                 ar_ready;
        logic                 aw_ready;
        logic                 w_ready;
        logic                 r_valid;
        logic [DATA_BITS-1:0] r_data;
        logic [1:0]           r_resp;
        logic                 r_last;
        logic [ID_BITS-1:0]   r_id;
        logic [USER_BITS-1:0] r_user;
        logic                 b_valid;
        logic [1:0]           b_resp;
        logic [ID_BITS-1:0]   b_id;
        logic [USER_BITS-1:0] b_user;
    } axi_slv_out_t;

    typedef struct packed {
        logic [ADDR_BITS-1:0] addr_start;
        logic [ADDR_BITS-1:0] addr_end;
    } mapinfo_t;

    // Single beat towards the storage, addr is an offset inside the window
    typedef struct packed {
        logic [ADDR_BITS-1:0]  addr;
        logic [7:0]            size;
        logic                  write;
        logic [DATA_BITS-1:0]  wdata;
        logic [DATA_BYTES-1:0] wstrb;
        logic                  last;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] rdata;
        logic                 err;
    } mem_resp_t;

    function automatic logic [7:0] size_to_bytes(input logic [2:0] size);
        return 8'd1 << size;
    endfunction

    // Next beat offset inside the 4 KiB page
    function automatic logic [11:0] next_beat_addr(input logic [11:0] addr,
                                                   input logic [7:0]  bytes,
                                                   input burst_e      burst,
                                                   input logic [8:0]  beats);
        logic [11:0] step;
        logic [11:0] mask;
        step = addr + {4'd0, bytes};
        // Wrap block is beat bytes times beat count, only 2/4/8/16 beats are legal
        mask = ({4'd0, bytes} * {3'd0, beats}) - 12'd1;
        case (burst)
            BURST_FIXED: return addr;
            BURST_WRAP:  return (addr & ~mask) | (step & mask);
            default:     return step;
        endcase
    endfunction

endpackage

// File: axi_slv/axi_slv.sv
// AXI4 slave bridge that splits bursts into single-beat memory requests
`timescale 1ns/100ps

module axi_slv
    import axi_sram_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_nrst,
    input  mapinfo_t     i_mapinfo,
    input  axi_slv_in_t  i_axi,
    output axi_slv_out_t o_axi,
    output logic         o_req_valid,
    output mem_req_t     o_req,
    input  logic         i_req_ready,
    input  logic         i_resp_valid,
    input  mem_resp_t    i_resp
);

    typedef enum logic [2:0] {
        R_IDLE,
        R_ADDR,
        R_DATA,
        R_LAST,
        R_WAIT_WR
    } rstate_e;

    typedef enum logic [2:0] {
        W_IDLE,
        W_REQ,
        W_PIPE,
        W_RESP,
        W_WAIT_RD,
        W_WAIT_RD_LIGHT,
        W_B
    } wstate_e;

    typedef struct packed {
        rstate_e              rstate;
        wstate_e              wstate;
        logic                 ar_ready;
        logic                 aw_ready;
        logic                 w_ready;
        logic [ADDR_BITS-1:0] ar_addr;
        logic [8:0]           ar_cnt;
        logic [8:0]           ar_beats;
        logic [7:0]           ar_bytes;
        burst_e               ar_burst;
        logic [ID_BITS-1:0]   ar_id;
        logic [USER_BITS-1:0] ar_user;
        logic                 rd_pend;
        logic [ADDR_BITS-1:0] aw_addr;
        logic [8:0]           aw_beats;
        logic [7:0]           aw_bytes;
        burst_e               aw_burst;
        logic [ID_BITS-1:0]   aw_id;
        logic [USER_BITS-1:0] aw_user;
        logic                 w_last;
        logic                 w_held;
        logic                 pend_wr;
        logic                 req_valid;
        mem_req_t             req;
        logic                 r_valid;
        logic                 r_last;
        logic                 r_err;
        logic [DATA_BITS-1:0] r_data;
        logic                 b_valid;
        logic                 b_err;
    } regs_t;

    regs_t r;
    regs_t rin;

    always_comb begin : comb_proc
        regs_t v;
        logic ar_hs;
        logic aw_hs;
        logic w_hs;
        logic r_hs;
        logic req_hs;
        logic rd_resp;
        logic wr_resp;
        logic rd_active;
        logic rd_issue;
        logic w_issue;
        logic w_have;
        logic [11:0] ar_next;
        logic [11:0] aw_next;

        v = r;
        ar_hs = i_axi.ar_valid & r.ar_ready;
        aw_hs = i_axi.aw_valid & r.aw_ready;
        w_hs = i_axi.w_valid & r.w_ready;
        r_hs = r.r_valid & i_axi.r_ready;
        req_hs = r.req_valid & i_req_ready;
        // Only one request is in flight, so its direction tags the response
        rd_resp = i_resp_valid & ~r.pend_wr;
        wr_resp = i_resp_valid & r.pend_wr;
        rd_active = (r.rstate != R_IDLE) && (r.rstate != R_WAIT_WR);
        rd_issue = 1'b0;
        w_issue = 1'b0;
        w_have = 1'b0;
        ar_next = next_beat_addr(r.ar_addr[11:0], r.ar_bytes, r.ar_burst, r.ar_beats);
        aw_next = next_beat_addr(r.aw_addr[11:0], r.aw_bytes, r.aw_burst, r.aw_beats);

        if (req_hs) begin
            v.req_valid = 1'b0;
            v.pend_wr = r.req.write;
        end
        if (r_hs) begin
            v.r_valid = 1'b0;
            v.r_last = 1'b0;
        end
        // Any failing beat of a burst marks the whole write
        if (wr_resp) begin
            v.b_err = r.b_err | i_resp.err;
        end

        case (r.rstate)
            R_IDLE: begin
                v.ar_ready = 1'b1;
                if (ar_hs) begin
                    v.ar_ready = 1'b0;
                    v.ar_addr = i_axi.ar.addr - i_mapinfo.addr_start;
                    v.ar_bytes = size_to_bytes(i_axi.ar.size);
                    v.ar_burst = i_axi.ar.burst;
                    v.ar_beats = {1'b0, i_axi.ar.len} + 9'd1;
                    v.ar_cnt = v.ar_beats;
                    v.ar_id = i_axi.ar.id;
                    v.ar_user = i_axi.ar.user;
                    // Writes take priority
                    if (i_axi.aw_valid || (r.wstate != W_IDLE)) begin
                        v.rstate = R_WAIT_WR;
                    end else begin
                        rd_issue = 1'b1;
                        v.rstate = R_ADDR;
                    end
                end
            end
            R_ADDR: begin
                if (req_hs) begin
                    v.ar_cnt = r.ar_cnt - 9'd1;
                    v.ar_addr = {r.ar_addr[ADDR_BITS-1:12], ar_next};
                    v.rd_pend = 1'b1;
                    v.rstate = R_DATA;
                end
            end
            R_DATA: begin
                if (rd_resp) begin
                    v.rd_pend = 1'b0;
                    v.r_valid = 1'b1;
                    v.r_data = i_resp.rdata;
                    v.r_err = i_resp.err;
                    v.r_last = (r.ar_cnt == 9'd0);
                    if (r.ar_cnt == 9'd0) begin
                        v.rstate = R_LAST;
                    end
                end else if (!r.rd_pend && (!r.r_valid || i_axi.r_ready)) begin
                    // Next beat only once the R register is free for its response
                    rd_issue = 1'b1;
                    v.rstate = R_ADDR;
                end
            end
            R_LAST: begin
                if (r_hs) begin
                    v.ar_ready = 1'b1;
                    v.rstate = R_IDLE;
                end
            end
            R_WAIT_WR: begin
                if (((r.wstate == W_IDLE) && !i_axi.aw_valid)
                        || (r.wstate == W_RESP) || (r.wstate == W_B)) begin
                    rd_issue = 1'b1;
                    v.rstate = R_ADDR;
                end
            end
            default: begin
                v.rstate = R_IDLE;
            end
        endcase

        case (r.wstate)
            W_IDLE: begin
                v.aw_ready = 1'b1;
                // W may come ahead of AW, hold it until the address arrives
                if (w_hs) begin
                    v.req.wdata = i_axi.w_data;
                    v.req.wstrb = i_axi.w_strb;
                    v.w_last = i_axi.w_last;
                    v.w_held = 1'b1;
                end
                v.w_ready = ~v.w_held;
                if (aw_hs) begin
                    w_have = v.w_held;
                    v.w_held = 1'b0;
                    v.aw_ready = 1'b0;
                    v.aw_addr = i_axi.aw.addr - i_mapinfo.addr_start;
                    v.aw_bytes = size_to_bytes(i_axi.aw.size);
                    v.aw_burst = i_axi.aw.burst;
                    v.aw_beats = {1'b0, i_axi.aw.len} + 9'd1;
                    v.aw_id = i_axi.aw.id;
                    v.aw_user = i_axi.aw.user;
                    if (rd_active) begin
                        v.w_ready = 1'b0;
                        v.wstate = w_have ? W_WAIT_RD_LIGHT : W_WAIT_RD;
                    end else if (w_have) begin
                        v.w_ready = 1'b0;
                        w_issue = 1'b1;
                        v.wstate = W_PIPE;
                    end else begin
                        v.w_ready = 1'b1;
                        v.wstate = W_REQ;
                    end
                end
            end
            W_REQ: begin
                if (w_hs) begin
                    v.req.wdata = i_axi.w_data;
                    v.req.wstrb = i_axi.w_strb;
                    v.w_last = i_axi.w_last;
                    v.w_ready = 1'b0;
                    w_issue = 1'b1;
                    v.wstate = W_PIPE;
                end
            end
            W_PIPE: begin
                if (req_hs) begin
                    if (r.req.last) begin
                        v.wstate = W_RESP;
                    end else begin
                        v.aw_addr = {r.aw_addr[ADDR_BITS-1:12], aw_next};
                        v.w_ready = 1'b1;
                        v.wstate = W_REQ;
                    end
                end
            end
            W_RESP: begin
                if (wr_resp) begin
                    v.b_valid = 1'b1;
                    v.wstate = W_B;
                end
            end
            W_WAIT_RD: begin
                if (!rd_active || (r_hs && r.r_last)) begin
                    v.w_ready = 1'b1;
                    v.wstate = W_REQ;
                end
            end
            W_WAIT_RD_LIGHT: begin
                if (!rd_active || (r_hs && r.r_last)) begin
                    w_issue = 1'b1;
                    v.wstate = W_PIPE;
                end
            end
            W_B: begin
                if (r.b_valid && i_axi.b_ready) begin
                    v.b_valid = 1'b0;
                    v.b_err = 1'b0;
                    v.aw_ready = 1'b1;
                    v.w_ready = 1'b1;
                    v.wstate = W_IDLE;
                end
            end
            default: begin
                v.wstate = W_IDLE;
            end
        endcase

        if (rd_issue) begin
            v.req_valid = 1'b1;
            v.req.write = 1'b0;
            v.req.addr = v.ar_addr;
            v.req.size = v.ar_bytes;
            v.req.last = (v.ar_cnt == 9'd1);
        end
        if (w_issue) begin
            v.req_valid = 1'b1;
            v.req.write = 1'b1;
            v.req.addr = v.aw_addr;
            v.req.size = v.aw_bytes;
            v.req.last = v.w_last;
        end

        rin = v;
    end : comb_proc

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= '0;
        end else begin
            r <= rin;
        end
    end

    assign o_req_valid = r.req_valid;
    assign o_req = r.req;

    always_comb begin
        o_axi = '0;
        o_axi.ar_ready = r.ar_ready;
        o_axi.aw_ready = r.aw_ready;
        o_axi.w_ready = r.w_ready;
        o_axi.r_valid = r.r_valid;
        o_axi.r_data = r.r_data;
        o_axi.r_resp = r.r_err ? RESP_SLVERR : RESP_OKAY;
        o_axi.r_last = r.r_last;
        o_axi.r_id = r.ar_id;
        o_axi.r_user = r.ar_user;
        o_axi.b_valid = r.b_valid;
        o_axi.b_resp = r.b_err ? RESP_SLVERR : RESP_OKAY;
        o_axi.b_id = r.aw_id;
        o_axi.b_user = r.aw_user;
    end

    // R beat must hold until the master takes it
    a_r_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_axi.r_valid && !i_axi.r_ready) |=> (o_axi.r_valid && $stable(o_axi.r_data)));

    // No write beat reaches the storage while a read burst is running
    a_no_wr_in_rd: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_req_valid && o_req.write) |-> (r.rstate inside {R_IDLE, R_WAIT_WR}));

    a_b_no_wready: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_axi.b_valid && o_axi.w_ready));

endmodule

// File: hdl/sram_ctrl.sv
// Word-wide SRAM with byte-strobe writes and a registered single-beat response
`timescale 1ns/100ps

module sram_ctrl
    import axi_sram_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_nrst,
    input  mapinfo_t  i_mapinfo,
    input  logic      i_req_valid,
    input  mem_req_t  i_req,
    output logic      o_req_ready,
    output logic      o_resp_valid,
    output mem_resp_t o_resp
);

    logic [DATA_BITS-1:0] mem [MEM_WORDS];
    logic [ADDR_BITS-1:0] win_bytes;
    logic [MEM_AW-1:0]    word_idx;
    logic                 accept;
    logic                 in_range;

    // Storage accepts a beat every cycle
    assign o_req_ready = 1'b1;
    assign accept = i_req_valid & o_req_ready;

    // Offset must fall inside both the mapped window and the physical array
    assign win_bytes = i_mapinfo.addr_end - i_mapinfo.addr_start;
    assign in_range = (i_req.addr < win_bytes)
                   && (i_req.addr < ADDR_BITS'(MEM_WORDS * DATA_BYTES));
    assign word_idx = MEM_AW'(i_req.addr / DATA_BYTES);

    always_ff @(posedge i_clk) begin
        if (accept && i_req.write && in_range) begin
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (i_req.wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Writes and failed reads answer with zero data
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_resp <= '{
                rdata: (!i_req.write && in_range) ? mem[word_idx] : '0,
                err:   ~in_range
            };
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= accept;
        end
    end

    // A failing write leaves the addressed word as it was
    a_err_wr_keeps: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (accept && i_req.write && !in_range)
            |=> (mem[$past(word_idx)] === $past(mem[word_idx])));

endmodule

// File: hdl/axi_sram.sv
// AXI4 SRAM slave top, the bus bridge in front of the on-chip storage
`timescale 1ns/100ps

module axi_sram
    import axi_sram_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_nrst,
    input  mapinfo_t     i_mapinfo,
    input  axi_slv_in_t  i_axi,
    output axi_slv_out_t o_axi
);

    logic      req_valid;
    logic      req_ready;
    mem_req_t  req;
    logic      resp_valid;
    mem_resp_t resp;

    axi_slv u_axi_slv (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_mapinfo    (i_mapinfo),
        .i_axi        (i_axi),
        .o_axi        (o_axi),
        .o_req_valid  (req_valid),
        .o_req        (req),
        .i_req_ready  (req_ready),
        .i_resp_valid (resp_valid),
        .i_resp       (resp)
    );

    sram_ctrl u_sram_ctrl (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_mapinfo    (i_mapinfo),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp       (resp)
    );

endmodule

// File: dv/axi_sram_tests.svh
// AXI4 master-side channel drivers and the directed burst tests
    task automatic fill_write_beats(input int len, input logic full);
        int i;
        for (i = 0; i <= len; i++) begin
            wr_data[i] = {$urandom, $urandom};
            wr_strb[i] = full ? 8'hFF : 8'($urandom);
        end
    endtask

    // AW and W go out together, then the task waits for B
    task automatic axi_write(input logic [ADDR_BITS-1:0] addr, input int len,
                             input burst_e burst, input logic [ID_BITS-1:0] id);
        int beat;
        int wait_cnt;
        logic aw_done;
        logic w_done;
        logic b_seen;
        beat = 0;
        wait_cnt = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        b_seen = 1'b0;
        @(posedge i_clk);
        aw_valid <= 1'b1;
        aw_ch <= '{addr: addr, len: 8'(len), size: BEAT_SIZE, burst: burst, id: id,
                   user: id[0]};
        w_valid <= 1'b1;
        w_data <= wr_data[0];
        w_strb <= wr_strb[0];
        w_last <= (len == 0);
        while (!(aw_done && w_done) && wait_cnt < HS_LIMIT) begin
            @(posedge i_clk);
            wait_cnt++;
            if (aw_valid && axi_out.aw_ready) begin
                aw_valid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_valid && axi_out.w_ready) begin
                beat++;
                wait_cnt = 0;
                if (beat > len) begin
                    w_valid <= 1'b0;
                    w_last <= 1'b0;
                    w_done = 1'b1;
                end else begin
                    w_data <= wr_data[beat];
                    w_strb <= wr_strb[beat];
                    w_last <= (beat == len);
                end
            end
        end
        if (!(aw_done && w_done)) begin
            n_errors++;
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            $display("Write to %h stalled on the address or data channel", addr);
        end
        wait_cnt = 0;
        while (!b_seen && wait_cnt < HS_LIMIT) begin
            @(posedge i_clk);
            wait_cnt++;
            if (axi_out.b_valid && b_ready) begin
                b_resp_got = axi_out.b_resp;
                b_id_got = axi_out.b_id;
                b_user_got = axi_out.b_user;
                b_seen = 1'b1;
            end
        end
        if (!b_seen) begin
            n_errors++;
            $display("No write response arrived for the write to %h", addr);
        end
    endtask

    task automatic axi_read(input logic [ADDR_BITS-1:0] addr, input int len,
                            input burst_e burst, input logic [ID_BITS-1:0] id);
        int wait_cnt;
        logic done;
        wait_cnt = 0;
        done = 1'b0;
        rd_count = 0;
        @(posedge i_clk);
        ar_valid <= 1'b1;
        ar_ch <= '{addr: addr, len: 8'(len), size: BEAT_SIZE, burst: burst, id: id,
                   user: id[0]};
        while (!done && wait_cnt < HS_LIMIT) begin
            @(posedge i_clk);
            wait_cnt++;
            if (ar_valid && axi_out.ar_ready) begin
                ar_valid <= 1'b0;
            end
            if (axi_out.r_valid && r_ready) begin
                rd_data[rd_count] = axi_out.r_data;
                rd_resp[rd_count] = axi_out.r_resp;
                rd_last[rd_count] = axi_out.r_last;
                rd_id[rd_count] = axi_out.r_id;
                rd_user[rd_count] = axi_out.r_user;
                rd_count++;
                wait_cnt = 0;
                // A burst running past its length ends here and fails the r_last check
                if (axi_out.r_last || rd_count > len) begin
                    done = 1'b1;
                end
            end
        end
        if (!done) begin
            n_errors++;
            ar_valid <= 1'b0;
            $display("Read burst at %h stalled after %0d beats", addr, rd_count);
        end
    endtask

    task automatic check_b(input logic [1:0] exp_resp, input logic [ID_BITS-1:0] id);
        compare("b_resp", exp_resp, b_resp_got);
        compare("b_id", id, b_id_got);
        compare("b_user", id[0], b_user_got);
    endtask

    task automatic single_write_read();
        @(posedge i_clk);
        compare("r_valid after reset", 1'b0, axi_out.r_valid);
        compare("b_valid after reset", 1'b0, axi_out.b_valid);
        fill_write_beats(0, 1'b1);
        axi_write(MAP_START + 32'h40, 0, BURST_INCR, 4'h3);
        apply_write_to_model('h40, 0, BURST_INCR);
        check_b(RESP_OKAY, 4'h3);
        axi_read(MAP_START + 32'h40, 0, BURST_INCR, 4'hC);
        check_read_beats('h40, 0, BURST_INCR, 4'hC);
    endtask

    // Full-strobe fill first, so partial strobes merge over known bytes
    task automatic incr_partial_strobes();
        fill_write_beats(7, 1'b1);
        axi_write(MAP_START + 32'h80, 7, BURST_INCR, 4'h1);
        apply_write_to_model('h80, 7, BURST_INCR);
        check_b(RESP_OKAY, 4'h1);
        fill_write_beats(7, 1'b0);
        axi_write(MAP_START + 32'h80, 7, BURST_INCR, 4'h2);
        apply_write_to_model('h80, 7, BURST_INCR);
        check_b(RESP_OKAY, 4'h2);
        axi_read(MAP_START + 32'h80, 7, BURST_INCR, 4'h7);
        check_read_beats('h80, 7, BURST_INCR, 4'h7);
    endtask

    // Starts at the third beat of a 32-byte block, so beats 3 and 4 wrap to its base
    task automatic wrap_placement();
        fill_write_beats(3, 1'b1);
        axi_write(MAP_START + 32'h110, 3, BURST_WRAP, 4'h4);
        apply_write_to_model('h110, 3, BURST_WRAP);
        check_b(RESP_OKAY, 4'h4);
        axi_read(MAP_START + 32'h100, 3, BURST_INCR, 4'hB);
        check_read_beats('h100, 3, BURST_INCR, 4'hB);
    endtask

    task automatic fixed_overwrite();
        fill_write_beats(0, 1'b1);
        axi_write(MAP_START + 32'h200, 0, BURST_INCR, 4'h5);
        apply_write_to_model('h200, 0, BURST_INCR);
        check_b(RESP_OKAY, 4'h5);
        fill_write_beats(3, 1'b0);
        axi_write(MAP_START + 32'h200, 3, BURST_FIXED, 4'h6);
        apply_write_to_model('h200, 3, BURST_FIXED);
        check_b(RESP_OKAY, 4'h6);
        axi_read(MAP_START + 32'h200, 3, BURST_FIXED, 4'hD);
        check_read_beats('h200, 3, BURST_FIXED, 4'hD);
    endtask

    // Offsets from 0xC00 lie inside the SRAM but outside the mapped window
    // Offset 0x1040 folds onto the word at 0x40 if a failing write reached the array
    task automatic out_of_window();
        fill_write_beats(1, 1'b1);
        axi_write(MAP_START + 32'h1040, 1, BURST_INCR, 4'h8);
        apply_write_to_model('h1040, 1, BURST_INCR);
        check_b(RESP_SLVERR, 4'h8);
        axi_read(MAP_START + 32'hC00, 1, BURST_INCR, 4'hA);
        check_read_beats('hC00, 1, BURST_INCR, 4'hA);
        axi_read(MAP_START + 32'h40, 0, BURST_INCR, 4'h2);
        check_read_beats('h40, 0, BURST_INCR, 4'h2);
    endtask

    // B must hold with aw_ready low for as long as b_ready stays low
    task automatic write_before_read();
        int hold;
        int wait_cnt;
        hold = $urandom_range(10, 0);
        wait_cnt = 0;
        fill_write_beats(0, 1'b1);
        @(posedge i_clk);
        b_ready <= 1'b0;
        fork
            axi_write(MAP_START + 32'h300, 0, BURST_INCR, 4'h6);
            axi_read(MAP_START + 32'h300, 0, BURST_INCR, 4'h9);
            begin
                while (!axi_out.b_valid && wait_cnt < HS_LIMIT) begin
                    @(posedge i_clk);
                    wait_cnt++;
                end
                repeat (hold) begin
                    @(posedge i_clk);
                    compare("b_valid while b_ready low", 1'b1, axi_out.b_valid);
                    compare("aw_ready while b_ready low", 1'b0, axi_out.aw_ready);
                end
                b_ready <= 1'b1;
            end
        join
        apply_write_to_model('h300, 0, BURST_INCR);
        check_b(RESP_OKAY, 4'h6);
        check_read_beats('h300, 0, BURST_INCR, 4'h9);
    endtask

// File: dv/axi_sram_tb.sv
// Testbench for the AXI4 SRAM slave, directed burst tests against a byte-level memory model
`timescale 1ns/100ps

module axi_sram_tb
    import axi_sram_pkg::*;
();

    localparam logic [ADDR_BITS-1:0] MAP_START = 32'h4000_0000;
    localparam logic [ADDR_BITS-1:0] MAP_END = 32'h4000_0C00;
    localparam int WIN_BYTES = 'hC00;
    localparam logic [2:0] BEAT_SIZE = 3'd3;
    localparam int HS_LIMIT = 200;
    // Beats issued by the whole test sequence, drives the watchdog limit
    localparam int TOTAL_BEATS = 50;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

    logic         i_clk;
    logic         i_nrst;
    mapinfo_t     mapinfo;
    axi_slv_in_t  axi_in;
    axi_slv_out_t axi_out;

    logic                  ar_valid;
    axi_ax_t               ar_ch;
    logic                  aw_valid;
    axi_ax_t               aw_ch;
    logic                  w_valid;
    logic [DATA_BITS-1:0]  w_data;
    logic [DATA_BYTES-1:0] w_strb;
    logic                  w_last;
    logic                  r_ready;
    logic                  b_ready;

    // Beat buffers shared by the drivers and the checks
    logic [DATA_BITS-1:0]  wr_data [16];
    logic [DATA_BYTES-1:0] wr_strb [16];
    logic [DATA_BITS-1:0]  rd_data [16];
    logic [1:0]            rd_resp [16];
    logic                  rd_last [16];
    logic [ID_BITS-1:0]    rd_id [16];
    logic [USER_BITS-1:0]  rd_user [16];
    int                    rd_count;
    logic [1:0]            b_resp_got;
    logic [ID_BITS-1:0]    b_id_got;
    logic [USER_BITS-1:0]  b_user_got;

    logic [7:0] model_mem [4096];
    int         n_checks;
    int         n_errors;

    assign axi_in = '{ar_valid: ar_valid, ar: ar_ch, aw_valid: aw_valid, aw: aw_ch,
                      w_valid: w_valid, w_data: w_data, w_strb: w_strb, w_last: w_last,
                      r_ready: r_ready, b_ready: b_ready};

    axi_sram u_axi_sram (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_mapinfo (mapinfo),
        .i_axi     (axi_in),
        .o_axi     (axi_out)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Watchdog expired, the tests did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Offset of the beat after off, AXI rules with a 4 KiB page boundary
    function automatic int step_offset(input int off, input int bytes, input burst_e burst,
                                       input int beats);
        int blk;
        int base;
        case (burst)
            BURST_FIXED: return off;
            BURST_WRAP: begin
                blk = bytes * beats;
                base = off - (off % blk);
                return base + ((off - base + bytes) % blk);
            end
            default: return off - (off % 4096) + (((off % 4096) + bytes) % 4096);
        endcase
    endfunction

    function automatic logic [63:0] expected_word(input int off);
        logic [63:0] word;
        int base;
        int b;
        base = off - (off % DATA_BYTES);
        for (b = 0; b < DATA_BYTES; b++) begin
            word[8*b +: 8] = model_mem[base + b];
        end
        return word;
    endfunction

    // Beats outside the window leave the model untouched
    task automatic apply_write_to_model(input int off, input int len, input burst_e burst);
        int cur;
        int base;
        int beat;
        int b;
        cur = off;
        for (beat = 0; beat <= len; beat++) begin
            if (cur < WIN_BYTES) begin
                base = cur - (cur % DATA_BYTES);
                for (b = 0; b < DATA_BYTES; b++) begin
                    if (wr_strb[beat][b]) begin
                        model_mem[base + b] = wr_data[beat][8*b +: 8];
                    end
                end
            end
            cur = step_offset(cur, DATA_BYTES, burst, len + 1);
        end
    endtask

    task automatic check_read_beats(input int off, input int len, input burst_e burst,
                                    input logic [ID_BITS-1:0] id);
        int cur;
        int beat;
        cur = off;
        compare("r beat count", len + 1, rd_count);
        for (beat = 0; beat <= len && beat < rd_count; beat++) begin
            compare("r_id", id, rd_id[beat]);
            compare("r_user", id[0], rd_user[beat]);
            compare("r_last", beat == len, rd_last[beat]);
            if (cur < WIN_BYTES) begin
                compare("r_resp", RESP_OKAY, rd_resp[beat]);
                compare("r_data", expected_word(cur), rd_data[beat]);
            end else begin
                compare("r_resp", RESP_SLVERR, rd_resp[beat]);
            end
            cur = step_offset(cur, DATA_BYTES, burst, len + 1);
        end
    endtask

`include "axi_sram_tests.svh"

    initial begin : main
        void'($urandom(67));
        n_checks = 0;
        n_errors = 0;
        i_nrst = 1'b0;
        mapinfo = '{addr_start: MAP_START, addr_end: MAP_END};
        ar_valid = 1'b0;
        ar_ch = '0;
        aw_valid = 1'b0;
        aw_ch = '0;
        w_valid = 1'b0;
        w_data = '0;
        w_strb = '0;
        w_last = 1'b0;
        r_ready = 1'b1;
        b_ready = 1'b1;
        repeat (16) @(posedge i_clk);
        i_nrst <= 1'b1;

        single_write_read();
        incr_partial_strobes();
        wrap_placement();
        fixed_overwrite();
        out_of_window();
        write_before_read();

        repeat (4) @(posedge i_clk);
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: axi_sram.f
+incdir+dv
common/axi_sram_pkg.sv
axi_slv/axi_slv.sv
hdl/sram_ctrl.sv
hdl/axi_sram.sv
dv/axi_sram_tb.sv

// File: Bender.yml
package:
  name: axi_sram

sources:
  # RTL in compile order
  - files:
      - common/axi_sram_pkg.sv
      - axi_slv/axi_slv.sv
      - hdl/sram_ctrl.sv
      - hdl/axi_sram.sv

  # Testbench, the test tasks are included from dv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/axi_sram_tb.sv
